// ==== logic/dz_pkg.sv ====
// Shared sizes, register map, CSR bit positions and the RBUF/LPR
// register word for the 8-line receive multiplexer

package dz_pkg;

   //////////////////////////////
   // Sizes
   //////////////////////////////

   // Line count and field widths
   localparam int n_lines    = 8;
   localparam int line_w     = 3;
   localparam int char_w     = 8;

   // Silo word is line number above character
   localparam int silo_w     = line_w + char_w;
   localparam int silo_depth = 64;
   localparam int silo_ptr_w = 6;
   // One extra bit so the count can reach 64
   localparam int silo_cnt_w = 7;

   // Alarm once the silo holds this many or more
   localparam int alarm_level = 16;

   //////////////////////////////
   // Register map
   //////////////////////////////

   localparam int reg_w      = 16;
   localparam int apb_addr_w = 4;

   // Byte offsets
   localparam int csr_off  = 0;
   // RBUF on read, LPR on write
   localparam int rbuf_off = 4;

   // CSR bit positions
   localparam int csr_mse   = 0;
   // Flush, write-only, never stored
   localparam int csr_clr   = 4;
   localparam int csr_rie   = 6;
   // Silo not empty, read-only
   localparam int csr_rdone = 7;
   localparam int csr_sae   = 12;
   // Silo alarm, read-only
   localparam int csr_sa    = 13;

   //////////////////////////////
   // RBUF / LPR word
   //////////////////////////////

   // Same offset, decoded differently by direction
   typedef union packed {
      struct packed {
         logic              valid;
         logic [3:0]        zero;
         logic [line_w-1:0] line;
         logic [char_w-1:0] ch;
      } rbuf;
      struct packed {
         logic [2:0]        zero_hi;
         logic              rcv_on;     // bit 12
         logic [8:0]        zero_lo;
         logic [line_w-1:0] line;
      } lpr;
   } dz_rbuf_lpr_u;

endpackage

// ==== logic/dz_silo.sv ====
// Receive silo, 64 words of line number and character, with depth
// count, full and alarm flags, flush and a registered head word
`timescale 1ns/10ps

module dz_silo
   import dz_pkg::*;
(
   input  logic              clk,
   input  logic              rst,
   input  logic              flush,
   input  logic              wr,
   input  logic              rd,
   input  logic [silo_w-1:0] din,
   output logic [silo_w-1:0] dout,
   output logic              full,
   output logic              alarm,
   output logic              empty
);

   // Storage, no reset on the payload
   logic [silo_w-1:0]     mem [silo_depth];

   logic [silo_ptr_w-1:0] wr_ptr;
   logic [silo_ptr_w-1:0] rd_ptr;
   logic [silo_cnt_w-1:0] depth;
   logic [silo_cnt_w-1:0] depth_next;
   logic                  do_wr;
   logic                  do_rd;
   logic                  empty_r;

   // Ignore pushes when full and pops when empty
   assign do_wr = wr & ~full;
   assign do_rd = rd & (depth != '0);

   // Depth update, simultaneous push and pop leaves it alone
   always_comb
   begin
      depth_next = depth;
      if (do_wr & ~do_rd)
         depth_next = depth + 1'b1;
      else if (do_rd & ~do_wr)
         depth_next = depth - 1'b1;
   end

   //////////////////////////////
   // Pointers and depth
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst | flush)
      begin
         wr_ptr  <= '0;
         rd_ptr  <= '0;
         depth   <= '0;
         empty_r <= 1'b1;
      end
      else
      begin
         if (do_wr)
            wr_ptr <= wr_ptr + 1'b1;
         if (do_rd)
            rd_ptr <= rd_ptr + 1'b1;
         depth <= depth_next;
         // Goes empty at once, leaves empty one cycle late
         // so the head register has caught up
         if (depth_next == '0)
            empty_r <= 1'b1;
         else
            empty_r <= (depth == '0);
      end
   end

   //////////////////////////////
   // Memory and head word
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (do_wr)
         mem[wr_ptr] <= din;
      // Head refreshed every cycle
      dout <= mem[rd_ptr];
   end

   // Status flags
   assign full  = (depth == silo_cnt_w'(silo_depth));
   assign alarm = (depth >= silo_cnt_w'(alarm_level));
   assign empty = empty_r;

endmodule

// ==== logic/dz_scan.sv ====
// Per-line holding registers and round-robin scanner feeding the silo
`timescale 1ns/10ps

module dz_scan
   import dz_pkg::*;
(
   input  logic                            clk,
   input  logic                            rst,
   input  logic                            mse,
   input  logic                            flush,
   input  logic [n_lines-1:0]              line_on,
   input  logic [n_lines-1:0]              line_stb,
   input  logic [n_lines-1:0][char_w-1:0]  line_char,
   input  logic                            full,
   output logic                            wr,
   output logic [silo_w-1:0]               din
);

   // One character and one flag per line
   logic [char_w-1:0]  hold_ch [n_lines];
   logic [n_lines-1:0] hold_v;

   // Line to start the next search from
   logic [line_w-1:0]  ptr;

   // Search result
   logic [line_w-1:0]  sel;
   logic               found;

   //////////////////////////////
   // Round-robin search
   //////////////////////////////

   // First held line at or above ptr, wrapping past line 7
   always_comb
   begin : pick
      logic [line_w-1:0] idx;
      found = 1'b0;
      sel   = ptr;
      for (int i = 0; i < n_lines; i++)
      begin
         idx = ptr + line_w'(i);
         if (!found && hold_v[idx])
         begin
            found = 1'b1;
            sel   = idx;
         end
      end
   end

   // At most one character per cycle, held back while silo full
   assign wr  = mse & found & ~full;
   assign din = {sel, hold_ch[sel]};

   //////////////////////////////
   // Holding flags and pointer
   //////////////////////////////

   always_ff @(posedge clk)
   begin
      if (rst | flush)
      begin
         hold_v <= '0;
         ptr    <= '0;
      end
      else
      begin
         // Served line clears, search moves past it
         if (wr)
         begin
            hold_v[sel] <= 1'b0;
            ptr         <= sel + 1'b1;
         end
         // New strobe wins over the clear on the same edge
         for (int i = 0; i < n_lines; i++)
         begin
            if (line_stb[i] & line_on[i])
               hold_v[i] <= 1'b1;
         end
      end
   end

   // Character capture, disabled lines dropped
   // A second strobe overwrites an unserved character
   always_ff @(posedge clk)
   begin
      for (int i = 0; i < n_lines; i++)
      begin
         if (line_stb[i] & line_on[i])
            hold_ch[i] <= line_char[i];
      end
   end

endmodule

// ==== logic/dz_regs.sv ====
// APB register block: CSR, RBUF read with pop, LPR line enables,
// flush pulse and receive interrupt
`timescale 1ns/10ps

module dz_regs
   import dz_pkg::*;
(
   input  logic                  clk,
   input  logic                  rst,
   // APB, zero wait
   input  logic                  psel,
   input  logic                  penable,
   input  logic                  pwrite,
   input  logic [apb_addr_w-1:0] paddr,
   input  logic [reg_w-1:0]      pwdata,
   output logic [reg_w-1:0]      prdata,
   // Silo side
   input  logic [silo_w-1:0]     dout,
   input  logic                  empty,
   input  logic                  alarm,
   output logic                  rd,
   output logic                  flush,
   // Scanner side
   output logic                  mse,
   output logic [n_lines-1:0]    line_on,
   output logic                  irq
);

   // Access phase qualifiers
   logic access;
   logic wr_acc;
   logic rd_acc;

   // Address decode
   logic sel_csr;
   logic sel_rbuf;

   // Stored CSR enables
   logic rie;
   logic sae;

   // Status
   logic rdone;
   logic sa;

   logic [reg_w-1:0] csr_word;
   dz_rbuf_lpr_u     rbuf_word;
   dz_rbuf_lpr_u     lpr_word;

   //////////////////////////////
   // Decode
   //////////////////////////////

   assign access = psel & penable;
   assign wr_acc = access & pwrite;
   assign rd_acc = access & ~pwrite;

   assign sel_csr  = (paddr == apb_addr_w'(csr_off));
   assign sel_rbuf = (paddr == apb_addr_w'(rbuf_off));

   // Status bits
   assign rdone = ~empty;
   // Alarm only reported when enabled
   assign sa    = sae & alarm;

   //////////////////////////////
   // Read side
   //////////////////////////////

   // CSR image, clear bit always reads zero
   always_comb
   begin
      csr_word            = '0;
      csr_word[csr_mse]   = mse;
      csr_word[csr_rie]   = rie;
      csr_word[csr_rdone] = rdone;
      csr_word[csr_sae]   = sae;
      csr_word[csr_sa]    = sa;
   end

   // RBUF view, all zero with no character waiting
   always_comb
   begin
      rbuf_word = '0;
      if (!empty)
      begin
         rbuf_word.rbuf.valid = 1'b1;
         rbuf_word.rbuf.line  = dout[silo_w-1 -: line_w];
         rbuf_word.rbuf.ch    = dout[char_w-1:0];
      end
   end

   // Read mux, live during the access cycle
   always_comb
   begin
      prdata = '0;
      if (rd_acc)
      begin
         if (sel_csr)
            prdata = csr_word;
         else if (sel_rbuf)
            prdata = rbuf_word;
      end
   end

   // Pop at the end of an RBUF read
   assign rd = rd_acc & sel_rbuf & ~empty;

   //////////////////////////////
   // Write side
   //////////////////////////////

   // LPR view of the write data
   assign lpr_word = pwdata;

   always_ff @(posedge clk)
   begin
      if (rst)
      begin
         mse     <= 1'b0;
         rie     <= 1'b0;
         sae     <= 1'b0;
         line_on <= '0;
      end
      else if (wr_acc & sel_csr)
      begin
         mse <= pwdata[csr_mse];
         rie <= pwdata[csr_rie];
         sae <= pwdata[csr_sae];
      end
      else if (wr_acc & sel_rbuf)
      begin
         // One line on or off per LPR write
         line_on[lpr_word.lpr.line] <= lpr_word.lpr.rcv_on;
      end
   end

   // Flush pulse on a CSR write with the clear bit
   assign flush = wr_acc & sel_csr & pwdata[csr_clr];

   //////////////////////////////
   // Interrupt
   //////////////////////////////

   // Alarm mode waits for 16 characters, else any character
   assign irq = rie & (sae ? alarm : rdone);

endmodule

// ==== logic/dz_top.sv ====
// Receive multiplexer top: register block, line scanner and silo
`timescale 1ns/10ps

module dz_top
   import dz_pkg::*;
(
   input  logic                           clk,
   input  logic                           rst,
   // APB
   input  logic                           psel,
   input  logic                           penable,
   input  logic                           pwrite,
   input  logic [apb_addr_w-1:0]          paddr,
   input  logic [reg_w-1:0]               pwdata,
   output logic [reg_w-1:0]               prdata,
   // Line receivers
   input  logic [n_lines-1:0]             line_stb,
   input  logic [n_lines-1:0][char_w-1:0] line_char,
   // Receive interrupt
   output logic                           irq
);

   // Register block controls
   logic               mse;
   logic [n_lines-1:0] line_on;
   logic               flush;
   logic               rd;

   // Scanner to silo
   logic               wr;
   logic [silo_w-1:0]  din;

   // Silo status
   logic [silo_w-1:0]  dout;
   logic               full;
   logic               alarm;
   logic               empty;

   //////////////////////////////
   // Instances
   //////////////////////////////

   dz_regs u_regs (
      .clk     (clk),
      .rst     (rst),
      .psel    (psel),
      .penable (penable),
      .pwrite  (pwrite),
      .paddr   (paddr),
      .pwdata  (pwdata),
      .prdata  (prdata),
      .dout    (dout),
      .empty   (empty),
      .alarm   (alarm),
      .rd      (rd),
      .flush   (flush),
      .mse     (mse),
      .line_on (line_on),
      .irq     (irq)
   );

   dz_scan u_scan (
      .clk       (clk),
      .rst       (rst),
      .mse       (mse),
      .flush     (flush),
      .line_on   (line_on),
      .line_stb  (line_stb),
      .line_char (line_char),
      .full      (full),
      .wr        (wr),
      .din       (din)
   );

   dz_silo u_silo (
      .clk   (clk),
      .rst   (rst),
      .flush (flush),
      .wr    (wr),
      .rd    (rd),
      .din   (din),
      .dout  (dout),
      .full  (full),
      .alarm (alarm),
      .empty (empty)
   );

endmodule

// ==== dv/tb_dz.sv ====
// Random self-checking testbench for the receive multiplexer
// Queue model, APB tasks, compare tasks and a closing report
`timescale 1ns/10ps

module tb_dz
   import dz_pkg::*;
();

   logic                           clk;
   logic                           rst;
   logic                           psel;
   logic                           penable;
   logic                           pwrite;
   logic [apb_addr_w-1:0]          paddr;
   logic [reg_w-1:0]               pwdata;
   logic [reg_w-1:0]               prdata;
   logic [n_lines-1:0]             line_stb;
   logic [n_lines-1:0][char_w-1:0] line_char;
   logic                           irq;

   // Model state
   logic                           m_mse;
   logic                           m_rie;
   logic                           m_sae;
   logic [n_lines-1:0]             m_line_on;
   dz_rbuf_lpr_u                   exp_q [$];

   // Bookkeeping
   integer                         seed;
   int                             checks;
   int                             errors;
   int                             tests;
   int                             test_base;

   dz_top uut (
      .clk       (clk),
      .rst       (rst),
      .psel      (psel),
      .penable   (penable),
      .pwrite    (pwrite),
      .paddr     (paddr),
      .pwdata    (pwdata),
      .prdata    (prdata),
      .line_stb  (line_stb),
      .line_char (line_char),
      .irq       (irq)
   );

   initial
   begin
      clk = 1'b0;
      forever #20 clk = ~clk;
   end

   //////////////////////////////
   // Model
   //////////////////////////////

   // Expected silo word as seen at RBUF
   function automatic dz_rbuf_lpr_u make_rbuf(input logic [line_w-1:0] line,
                                              input logic [char_w-1:0] ch);
      dz_rbuf_lpr_u w;
      w            = '0;
      w.rbuf.valid = 1'b1;
      w.rbuf.line  = line;
      w.rbuf.ch    = ch;
      return w;
   endfunction

   // CSR image from the model with status from queue depth
   function automatic logic [reg_w-1:0] exp_csr();
      logic [reg_w-1:0] w;
      w            = '0;
      w[csr_mse]   = m_mse;
      w[csr_rie]   = m_rie;
      w[csr_sae]   = m_sae;
      w[csr_rdone] = (exp_q.size() != 0);
      w[csr_sa]    = m_sae & (exp_q.size() >= alarm_level);
      return w;
   endfunction

   // Alarm mode needs 16 waiting and otherwise any one
   function automatic logic exp_irq();
      return m_rie & (m_sae ? (exp_q.size() >= alarm_level) : (exp_q.size() != 0));
   endfunction

   //////////////////////////////
   // Compare tasks
   //////////////////////////////

   task automatic check_rbuf(input dz_rbuf_lpr_u got, input dz_rbuf_lpr_u exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAIL %0t prdata(RBUF) got %h expected %h", $time, got, exp);
         errors++;
      end
   endtask

   task automatic check_csr(input logic [reg_w-1:0] got, input logic [reg_w-1:0] exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAIL %0t prdata(CSR) got %h expected %h", $time, got, exp);
         errors++;
      end
   endtask

   task automatic check_irq(input logic got, input logic exp);
      checks++;
      if (got !== exp)
      begin
         $display("FAIL %0t irq got %b expected %b", $time, got, exp);
         errors++;
      end
   endtask

   //////////////////////////////
   // APB tasks
   //////////////////////////////

   // Setup cycle then one access cycle
   task automatic apb_write(input logic [apb_addr_w-1:0] addr, input logic [reg_w-1:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b1;
      paddr   <= addr;
      pwdata  <= data;
      @(posedge clk);
      penable <= 1'b1;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
      pwrite  <= 1'b0;
   endtask

   // Read data sampled mid access cycle
   task automatic apb_read(input logic [apb_addr_w-1:0] addr, output logic [reg_w-1:0] data);
      @(posedge clk);
      psel    <= 1'b1;
      penable <= 1'b0;
      pwrite  <= 1'b0;
      paddr   <= addr;
      @(posedge clk);
      penable <= 1'b1;
      @(negedge clk);
      data = prdata;
      @(posedge clk);
      psel    <= 1'b0;
      penable <= 1'b0;
   endtask

   task automatic read_csr(output logic [reg_w-1:0] w);
      apb_read(apb_addr_w'(csr_off), w);
   endtask

   task automatic read_rbuf(output dz_rbuf_lpr_u u);
      logic [reg_w-1:0] w;
      apb_read(apb_addr_w'(rbuf_off), w);
      u = w;
   endtask

   // Clear bit empties the model too
   task automatic write_csr(input logic mse, input logic rie, input logic sae,
                            input logic clr);
      logic [reg_w-1:0] w;
      w          = '0;
      w[csr_mse] = mse;
      w[csr_rie] = rie;
      w[csr_sae] = sae;
      w[csr_clr] = clr;
      apb_write(apb_addr_w'(csr_off), w);
      m_mse = mse;
      m_rie = rie;
      m_sae = sae;
      if (clr)
         exp_q.delete();
   endtask

   // One line on or off
   task automatic write_lpr(input logic [line_w-1:0] line, input logic on);
      dz_rbuf_lpr_u w;
      w            = '0;
      w.lpr.line   = line;
      w.lpr.rcv_on = on;
      apb_write(apb_addr_w'(rbuf_off), w);
      m_line_on[line] = on;
   endtask

   //////////////////////////////
   // Line and silo helpers
   //////////////////////////////

   // One strobe and then a gap of 3 to 6 idle cycles
   task automatic send_char(input logic [line_w-1:0] line, input logic [char_w-1:0] ch);
      logic [n_lines-1:0] mask;
      logic [31:0]        r;
      mask       = '0;
      mask[line] = 1'b1;
      @(posedge clk);
      line_stb        <= mask;
      line_char[line] <= ch;
      @(posedge clk);
      line_stb <= '0;
      if (m_line_on[line])
         exp_q.push_back(make_rbuf(line, ch));
      r = $random(seed);
      repeat (3 + r[1:0]) @(posedge clk);
   endtask

   // Bounded poll of RDONE
   task automatic wait_rdone();
      logic [reg_w-1:0] w;
      int               n;
      w = '0;
      n = 0;
      while (!w[csr_rdone] && n < 20)
      begin
         read_csr(w);
         n++;
      end
      if (!w[csr_rdone])
      begin
         $display("ERROR %0t timeout, no character became ready in RBUF", $time);
         errors++;
      end
   endtask

   task automatic pop_and_check();
      dz_rbuf_lpr_u got;
      wait_rdone();
      read_rbuf(got);
      check_rbuf(got, exp_q.pop_front());
   endtask

   // Read until the model runs dry and then expect an idle silo
   task automatic drain();
      logic [reg_w-1:0] w;
      dz_rbuf_lpr_u     got;
      while (exp_q.size() > 0)
         pop_and_check();
      read_csr(w);
      check_csr(w, exp_csr());
      read_rbuf(got);
      check_rbuf(got, '0);
   endtask

   task automatic end_test(input string name);
      tests++;
      $display("test %0d %s done, %0d errors", tests, name, errors - test_base);
      test_base = errors;
   endtask

   //////////////////////////////
   // Stimulus
   //////////////////////////////

   initial
   begin
      logic [31:0]       r;
      logic [reg_w-1:0]  w;
      dz_rbuf_lpr_u      got;
      logic [line_w-1:0] last_line;

      seed      = 32'h620082c4;
      rst       = 1'b1;
      psel      = 1'b0;
      penable   = 1'b0;
      pwrite    = 1'b0;
      paddr     = '0;
      pwdata    = '0;
      line_stb  = '0;
      line_char = '0;
      m_mse     = 1'b0;
      m_rie     = 1'b0;
      m_sae     = 1'b0;
      m_line_on = '0;
      checks    = 0;
      errors    = 0;
      tests     = 0;
      test_base = 0;
      last_line = '0;

      repeat (8) @(posedge clk);
      rst <= 1'b0;

      // Reset values
      read_csr(w);
      check_csr(w, '0);
      read_rbuf(got);
      check_rbuf(got, '0);
      @(negedge clk);
      check_irq(irq, 1'b0);
      end_test("reset values");

      // Random lines on random enables
      write_csr(1'b1, 1'b0, 1'b0, 1'b0);
      for (int l = 0; l < n_lines; l++)
      begin
         r = $random(seed);
         write_lpr(line_w'(l), r[0]);
      end
      for (int i = 0; i < 24; i++)
      begin
         r = $random(seed);
         // Flip one enable half way
         if (i == 12)
            write_lpr(r[10:8], r[11]);
         send_char(r[2:0], r[15:8]);
      end
      drain();
      end_test("single characters");

      // All lines in one cycle after a flush
      write_csr(1'b1, 1'b0, 1'b0, 1'b1);
      for (int l = 0; l < n_lines; l++)
         write_lpr(line_w'(l), 1'b1);
      @(posedge clk);
      for (int l = 0; l < n_lines; l++)
      begin
         r = $random(seed);
         line_char[l] <= r[char_w-1:0];
         exp_q.push_back(make_rbuf(line_w'(l), r[char_w-1:0]));
      end
      line_stb <= '1;
      @(posedge clk);
      line_stb <= '0;
      drain();
      end_test("scan order");

      // Interrupt without alarm mode
      write_csr(1'b1, 1'b1, 1'b0, 1'b0);
      @(negedge clk);
      check_irq(irq, exp_irq());
      r = $random(seed);
      send_char(r[2:0], r[15:8]);
      wait_rdone();
      @(negedge clk);
      check_irq(irq, exp_irq());
      pop_and_check();
      @(negedge clk);
      check_irq(irq, exp_irq());
      // Alarm mode up through the level and back down
      write_csr(1'b1, 1'b1, 1'b1, 1'b0);
      for (int i = 0; i < alarm_level + 2; i++)
      begin
         r = $random(seed);
         send_char(r[2:0], r[15:8]);
         read_csr(w);
         check_csr(w, exp_csr());
         @(negedge clk);
         check_irq(irq, exp_irq());
      end
      while (exp_q.size() > 0)
      begin
         pop_and_check();
         @(negedge clk);
         check_irq(irq, exp_irq());
         read_csr(w);
         check_csr(w, exp_csr());
      end
      end_test("interrupt and alarm");

      // Fill the silo and hold six more on distinct lines
      write_csr(1'b1, 1'b0, 1'b0, 1'b0);
      for (int i = 0; i < silo_depth; i++)
      begin
         r = $random(seed);
         last_line = r[2:0];
         send_char(r[2:0], r[15:8]);
      end
      // Held lines picked in round-robin order past the last served
      for (int k = 0; k < 6; k++)
      begin
         r = $random(seed);
         send_char(last_line + line_w'(k + 1), r[15:8]);
      end
      read_csr(w);
      check_csr(w, exp_csr());
      // Scanner off so only the silo drains
      write_csr(1'b0, 1'b0, 1'b0, 1'b0);
      for (int i = 0; i < silo_depth; i++)
         pop_and_check();
      // Silo now empty with the six still in their holding registers
      read_csr(w);
      check_csr(w, '0);
      read_rbuf(got);
      check_rbuf(got, '0);
      // Scanner back on for the held characters
      write_csr(1'b1, 1'b0, 1'b0, 1'b0);
      drain();
      end_test("silo full");

      // Flush with characters waiting
      for (int i = 0; i < 5; i++)
      begin
         r = $random(seed);
         send_char(r[2:0], r[15:8]);
      end
      wait_rdone();
      write_csr(1'b1, 1'b0, 1'b0, 1'b1);
      read_csr(w);
      check_csr(w, exp_csr());
      read_rbuf(got);
      check_rbuf(got, '0);
      end_test("flush");

      $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
      if (errors == 0)
         $display(">>> PASS");
      else
         $display(">>> FAIL");
      $finish;
   end

endmodule

// ==== tb.f ====
logic/dz_pkg.sv
logic/dz_silo.sv
logic/dz_scan.sv
logic/dz_regs.sv
logic/dz_top.sv
dv/tb_dz.sv

// ==== Makefile ====
# Verilator build and run of the receive multiplexer testbench

VERILATOR ?= verilator
TOP       ?= tb_dz
FLIST     ?= tb.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing

.PHONY: sim clean

sim:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FLIST)
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; rc=$$?; cat $(LOG); exit $$rc
	@if grep -q '>>> FAIL' $(LOG); then exit 1; fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)
